//--- hdl/bank_if.sv
//######################################
// single bank write and read port
//######################################
`timescale 1ns/1ps

interface bank_if
    import global_buffer_pkg::*;
();

    logic                       wr_en;
    logic [BANK_ADDR_WIDTH-1:0] wr_addr;
    logic [BANK_DATA_WIDTH-1:0] wr_data;
    // bit mask, set bits are written
    logic [BANK_DATA_WIDTH-1:0] wr_bit_sel;

    logic                       rd_en;
    logic [BANK_ADDR_WIDTH-1:0] rd_addr;
    // back from the bank, same cycle
    logic [BANK_DATA_WIDTH-1:0] rd_data;

    // interconnect side
    modport ctrl (
        output wr_en, wr_addr, wr_data, wr_bit_sel,
        output rd_en, rd_addr,
        input  rd_data
    );

    // memory side
    modport mem (
        input  wr_en, wr_addr, wr_data, wr_bit_sel,
        input  rd_en, rd_addr,
        output rd_data
    );

endinterface

//--- hdl/glb_bank.sv
//######################################
// bank memory, bit-masked write,
// combinational read
//######################################
`timescale 1ns/1ps

module glb_bank
    import global_buffer_pkg::*;
(
    input  logic  clk,
    bank_if.mem   port
);

    localparam int depth = 2 ** BANK_ADDR_WIDTH;

    // word storage
    logic [BANK_DATA_WIDTH-1:0] words [depth];

    // old word and new word merged by the mask
    logic [BANK_DATA_WIDTH-1:0] wr_word;

    assign wr_word = (words[port.wr_addr] & ~port.wr_bit_sel)
                   | (port.wr_data & port.wr_bit_sel);

    // write lands at the clock edge
    always_ff @(posedge clk) begin
        if (port.wr_en) begin
            words[port.wr_addr] <= wr_word;
        end
    end

    // read address comes already registered from the interconnect
    // idle port returns zero
    always_comb begin
        if (port.rd_en) begin
            port.rd_data = words[port.rd_addr];
        end else begin
            port.rd_data = '0;
        end
    end

    // same-address write and read in one cycle
    // read sees the old word, write lands at the edge
    a_rw_same_addr: assert property (
        @(posedge clk)
        !(port.wr_en && port.rd_en && (port.wr_addr == port.rd_addr))
    ) else begin
        $warning("glb_bank: write and read to address %0d in one cycle, read returns old word",
                 port.rd_addr);
    end

endmodule

//--- hdl/glb_tile.sv
//######################################
// one tile: interconnect plus its banks
//######################################
`timescale 1ns/1ps

module glb_tile
    import global_buffer_pkg::*;
#(
    // column number this tile answers to
    parameter int tile_col = 0
) (
    input  logic                       clk,
    input  logic                       reset,
    ps_if.west                         ps_east,
    ps_if.east                         ps_west,
    input  logic [BANK_DATA_WIDTH-1:0] rd_data_west,
    output logic [BANK_DATA_WIDTH-1:0] rd_data_east
);

    // one port per bank
    bank_if bank_port [NUM_BANKS] ();

    // decode, pipelines, bypass
    ps_interconnect #(
        .tile_col     (tile_col)
    ) ps_interconnect_i (
        .clk          (clk),
        .reset        (reset),
        .ps_east      (ps_east),
        .ps_west      (ps_west),
        .rd_data_west (rd_data_west),
        .rd_data_east (rd_data_east),
        .banks        (bank_port)
    );

    // banks, selected by the bank field
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        glb_bank glb_bank_i (
            .clk  (clk),
            .port (bank_port[b])
        );
    end

endmodule

//--- hdl/global_buffer.sv
//######################################
// global buffer top level with the
// processor port and westward tile chain
//######################################
`timescale 1ns/1ps

module global_buffer
    import global_buffer_pkg::*;
#(
    // built columns up to 2**TILE_SEL_ADDR_WIDTH
    parameter int num_tiles = 3
) (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         wr_en,
    input  logic [BANK_DATA_WIDTH/8-1:0] wr_strb,
    input  logic [GLB_ADDR_WIDTH-1:0]    wr_addr,
    input  logic [BANK_DATA_WIDTH-1:0]   wr_data,
    input  logic                         rd_en,
    input  logic [GLB_ADDR_WIDTH-1:0]    rd_addr,
    output logic [BANK_DATA_WIDTH-1:0]   rd_data
);

    // request segments with index 0 at the east end
    ps_if ps_chain [num_tiles+1] ();
    // read data segments flowing east
    logic [BANK_DATA_WIDTH-1:0] rd_chain [num_tiles+1];

    // processor port enters tile 0
    assign ps_chain[0].wr_en   = wr_en;
    assign ps_chain[0].wr_strb = wr_strb;
    assign ps_chain[0].wr_addr = wr_addr;
    assign ps_chain[0].wr_data = wr_data;
    assign ps_chain[0].rd_en   = rd_en;
    assign ps_chain[0].rd_addr = rd_addr;

    for (genvar t = 0; t < num_tiles; t++) begin : g_tile
        glb_tile #(
            .tile_col     (t)
        ) glb_tile_i (
            .clk          (clk),
            .reset        (reset),
            .ps_east      (ps_chain[t]),
            .ps_west      (ps_chain[t+1]),
            .rd_data_west (rd_chain[t+1]),
            .rd_data_east (rd_chain[t])
        );
    end

    // zero enters west of the last tile so unbuilt columns read zero
    assign rd_chain[num_tiles] = '0;
    // tile 0 holds the last returned word
    assign rd_data = rd_chain[0];

endmodule

//--- hdl/global_buffer_pkg.sv
//######################################
// widths and field layout shared by the
// global buffer tiles, banks and top level
//######################################
package global_buffer_pkg;

    // one bank word
    localparam int BANK_DATA_WIDTH = 64;

    // word offset inside a bank
    localparam int BANK_ADDR_WIDTH = 6;

    // bank select inside a tile
    localparam int BANK_SEL_ADDR_WIDTH = 1;

    // banks per tile, one per bank select code
    localparam int NUM_BANKS = 2 ** BANK_SEL_ADDR_WIDTH;

    // tile column select
    // top level may build fewer columns than this field can name
    localparam int TILE_SEL_ADDR_WIDTH = 2;

    // processor address, low to high:
    //   bank offset, bank select, tile select
    localparam int GLB_ADDR_WIDTH = BANK_ADDR_WIDTH
                                  + BANK_SEL_ADDR_WIDTH
                                  + TILE_SEL_ADDR_WIDTH;

endpackage

//--- hdl/ps_if.sv
//######################################
// processor request bundle between tiles
//######################################
`timescale 1ns/1ps

interface ps_if
    import global_buffer_pkg::*;
();

    // write request
    logic                         wr_en;
    // one bit per byte lane
    logic [BANK_DATA_WIDTH/8-1:0] wr_strb;
    logic [GLB_ADDR_WIDTH-1:0]    wr_addr;
    logic [BANK_DATA_WIDTH-1:0]   wr_data;

    // read request
    // read data runs the other way, outside this bundle
    logic                         rd_en;
    logic [GLB_ADDR_WIDTH-1:0]    rd_addr;

    // eastern side, drives the request west
    modport east (
        output wr_en,
        output wr_strb,
        output wr_addr,
        output wr_data,
        output rd_en,
        output rd_addr
    );

    // western side, receives it
    modport west (
        input  wr_en,
        input  wr_strb,
        input  wr_addr,
        input  wr_data,
        input  rd_en,
        input  rd_addr
    );

endinterface

//--- hdl/ps_interconnect.sv
//######################################
// tile request decode, bank pipelines,
// read merge and westward bypass
//######################################
`timescale 1ns/1ps

module ps_interconnect
    import global_buffer_pkg::*;
#(
    parameter int tile_col = 0
) (
    input  logic                       clk,
    input  logic                       reset,
    ps_if.west                         ps_east,
    ps_if.east                         ps_west,
    input  logic [BANK_DATA_WIDTH-1:0] rd_data_west,
    output logic [BANK_DATA_WIDTH-1:0] rd_data_east,
    bank_if.ctrl                       banks [NUM_BANKS]
);

    // field positions in the processor address
    localparam int bank_lsb = BANK_ADDR_WIDTH;
    localparam int tile_lsb = BANK_ADDR_WIDTH + BANK_SEL_ADDR_WIDTH;
    localparam logic [TILE_SEL_ADDR_WIDTH-1:0] my_col = TILE_SEL_ADDR_WIDTH'(tile_col);

    // decode
    logic                           wr_hit;
    logic                           rd_hit;
    logic [BANK_SEL_ADDR_WIDTH-1:0] wr_bank_sel;
    logic [BANK_SEL_ADDR_WIDTH-1:0] rd_bank_sel;
    logic [BANK_DATA_WIDTH-1:0]     wr_bit_sel;

    // bank port, one register after the request
    logic [NUM_BANKS-1:0]           wr_en_d1;
    logic [NUM_BANKS-1:0]           rd_en_d1;
    logic [BANK_ADDR_WIDTH-1:0]     wr_addr_d1;
    logic [BANK_DATA_WIDTH-1:0]     wr_data_d1;
    logic [BANK_DATA_WIDTH-1:0]     wr_bit_sel_d1;
    logic [BANK_ADDR_WIDTH-1:0]     rd_addr_d1;

    // read return
    logic                           rd_hit_d1;
    logic                           rd_hit_d2;
    logic [BANK_SEL_ADDR_WIDTH-1:0] rd_bank_sel_d1;
    logic [BANK_SEL_ADDR_WIDTH-1:0] rd_bank_sel_d2;
    logic                           rd_any_d1;
    logic                           rd_any_d2;
    logic [BANK_DATA_WIDTH-1:0]     bank_rd_data [NUM_BANKS];
    logic [BANK_DATA_WIDTH-1:0]     bank_rd_data_d1 [NUM_BANKS];
    logic [BANK_DATA_WIDTH-1:0]     rd_data_sel;
    logic [BANK_DATA_WIDTH-1:0]     rd_data_hold;

    // tile match on the top field
    assign wr_hit = ps_east.wr_en && (ps_east.wr_addr[tile_lsb +: TILE_SEL_ADDR_WIDTH] == my_col);
    assign rd_hit = ps_east.rd_en && (ps_east.rd_addr[tile_lsb +: TILE_SEL_ADDR_WIDTH] == my_col);
    assign wr_bank_sel = ps_east.wr_addr[bank_lsb +: BANK_SEL_ADDR_WIDTH];
    assign rd_bank_sel = ps_east.rd_addr[bank_lsb +: BANK_SEL_ADDR_WIDTH];

    // byte strobe to bit mask
    always_comb begin
        for (int i = 0; i < BANK_DATA_WIDTH/8; i++) begin
            wr_bit_sel[i*8 +: 8] = {8{ps_east.wr_strb[i]}};
        end
    end

    // one-hot bank enables and read flags
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_en_d1  <= '0;
            rd_en_d1  <= '0;
            rd_hit_d1 <= 1'b0;
            rd_hit_d2 <= 1'b0;
            rd_any_d1 <= 1'b0;
            rd_any_d2 <= 1'b0;
        end else begin
            wr_en_d1  <= wr_hit ? (NUM_BANKS'(1) << wr_bank_sel) : '0;
            rd_en_d1  <= rd_hit ? (NUM_BANKS'(1) << rd_bank_sel) : '0;
            rd_hit_d1 <= rd_hit;
            rd_hit_d2 <= rd_hit_d1;
            // any read on the chain, hit or not
            rd_any_d1 <= ps_east.rd_en;
            rd_any_d2 <= rd_any_d1;
        end
    end

    // address, data, mask and bank select
    always_ff @(posedge clk) begin
        wr_addr_d1     <= ps_east.wr_addr[BANK_ADDR_WIDTH-1:0];
        wr_data_d1     <= ps_east.wr_data;
        wr_bit_sel_d1  <= wr_bit_sel;
        rd_addr_d1     <= ps_east.rd_addr[BANK_ADDR_WIDTH-1:0];
        rd_bank_sel_d1 <= rd_bank_sel;
        rd_bank_sel_d2 <= rd_bank_sel_d1;
    end

    // drive each bank port, collect its read word
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
        assign banks[b].wr_en      = wr_en_d1[b];
        assign banks[b].wr_addr    = wr_addr_d1;
        assign banks[b].wr_data    = wr_data_d1;
        assign banks[b].wr_bit_sel = wr_bit_sel_d1;
        assign banks[b].rd_en      = rd_en_d1[b];
        assign banks[b].rd_addr    = rd_addr_d1;
        assign bank_rd_data[b]     = banks[b].rd_data;
    end

    // second read stage, only when this tile was hit
    always_ff @(posedge clk) begin
        if (rd_hit_d1) begin
            bank_rd_data_d1 <= bank_rd_data;
        end
    end

    // own bank wins over west data
    assign rd_data_sel = rd_hit_d2 ? bank_rd_data_d1[rd_bank_sel_d2] : rd_data_west;
    // no read returning, keep last word
    assign rd_data_east = rd_any_d2 ? rd_data_sel : rd_data_hold;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_data_hold <= '0;
        end else begin
            rd_data_hold <= rd_data_east;
        end
    end

    // westward bypass, same cycle
    assign ps_west.wr_en   = ps_east.wr_en;
    assign ps_west.wr_strb = ps_east.wr_strb;
    assign ps_west.wr_addr = ps_east.wr_addr;
    assign ps_west.wr_data = ps_east.wr_data;
    assign ps_west.rd_en   = ps_east.rd_en;
    assign ps_west.rd_addr = ps_east.rd_addr;

    a_wr_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(wr_en_d1))
        else $error("ps_interconnect col %0d: more than one bank write enable", tile_col);
    a_rd_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(rd_en_d1))
        else $error("ps_interconnect col %0d: more than one bank read enable", tile_col);
    // request strobes from the east and the bank enables they create
    a_en_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown({ps_east.wr_en, ps_east.rd_en, wr_en_d1, rd_en_d1, rd_any_d2}))
        else $error("ps_interconnect col %0d: unknown read or write enable", tile_col);

endmodule

//--- list.f
hdl/global_buffer_pkg.sv
hdl/ps_if.sv
hdl/bank_if.sv
hdl/glb_bank.sv
hdl/ps_interconnect.sv
hdl/glb_tile.sv
hdl/global_buffer.sv
tb/global_buffer_tb.sv

//--- run.sh
#!/bin/sh
# build the global buffer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module global_buffer_tb -o global_buffer_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/global_buffer_sim > sim.log 2>&1
cat sim.log
# result comes from the log
grep -q "SIMULATION FAILED" sim.log && exit 1 || exit 0

//--- tb/global_buffer_tb.sv
//######################################
// global buffer testbench: op table,
// reference memory, read checks, watchdog
//######################################
`timescale 1ns/1ps

module global_buffer_tb
    import global_buffer_pkg::*;
();

    localparam int num_tiles    = 3;
    localparam int clk_period   = 8;
    localparam int reset_cycles = 16;

    typedef enum logic [1:0] {OP_IDLE, OP_WRITE, OP_READ} op_kind_t;

    // one table row, applied in one clock cycle
    typedef struct {
        op_kind_t                     kind;
        logic [GLB_ADDR_WIDTH-1:0]    addr;
        logic [BANK_DATA_WIDTH-1:0]   data;
        logic [BANK_DATA_WIDTH/8-1:0] strb;
    } op_t;

    logic                         clk;
    logic                         reset;
    logic                         wr_en;
    logic [BANK_DATA_WIDTH/8-1:0] wr_strb;
    logic [GLB_ADDR_WIDTH-1:0]    wr_addr;
    logic [BANK_DATA_WIDTH-1:0]   wr_data;
    logic                         rd_en;
    logic [GLB_ADDR_WIDTH-1:0]    rd_addr;
    logic [BANK_DATA_WIDTH-1:0]   rd_data;

    op_t                        op_table [$];
    logic                       table_ready;
    logic [31:0]                lcg_state;
    longint                     limit_ns;
    int                         error_count;
    int                         check_count;
    // reference memory over the whole address space
    logic [BANK_DATA_WIDTH-1:0] ref_mem [2**GLB_ADDR_WIDTH];
    // reads in flight: expected word and the row that issued it
    logic [BANK_DATA_WIDTH-1:0] exp_word [$];
    int                         exp_row [$];
    // last word returned, rd_data holds it
    logic [BANK_DATA_WIDTH-1:0] last_word;

    global_buffer #(
        .num_tiles (num_tiles)
    ) global_buffer_i (
        .clk       (clk),
        .reset     (reset),
        .wr_en     (wr_en),
        .wr_strb   (wr_strb),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period/2) clk = ~clk;
    end

    // lcg, numerical recipes constants
    function logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function logic [BANK_DATA_WIDTH-1:0] rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi, lo};
    endfunction

    // tile field on top, then bank select, then word offset
    function automatic logic [GLB_ADDR_WIDTH-1:0] make_addr(int tile, int bank, int offset);
        return {TILE_SEL_ADDR_WIDTH'(tile), BANK_SEL_ADDR_WIDTH'(bank),
                BANK_ADDR_WIDTH'(offset)};
    endfunction

    // strobed bytes come from the new word, the rest stay
    function automatic logic [BANK_DATA_WIDTH-1:0] merge_bytes(
        logic [BANK_DATA_WIDTH-1:0]   old_word,
        logic [BANK_DATA_WIDTH-1:0]   new_word,
        logic [BANK_DATA_WIDTH/8-1:0] strb
    );
        logic [BANK_DATA_WIDTH-1:0] result;
        result = old_word;
        for (int i = 0; i < BANK_DATA_WIDTH/8; i++) begin
            if (strb[i]) begin
                result[i*8 +: 8] = new_word[i*8 +: 8];
            end
        end
        return result;
    endfunction

    function automatic void add_op(op_kind_t kind, logic [GLB_ADDR_WIDTH-1:0] addr,
                                   logic [BANK_DATA_WIDTH-1:0] data,
                                   logic [BANK_DATA_WIDTH/8-1:0] strb);
        op_t op;
        op.kind = kind;
        op.addr = addr;
        op.data = data;
        op.strb = strb;
        op_table.push_back(op);
    endfunction

    task automatic build_table();
        int offsets [3];
        offsets[0] = 0;
        offsets[1] = 17;
        offsets[2] = 63;
        // idle after reset, rd_data stays zero
        repeat (3) add_op(OP_IDLE, '0, '0, '0);
        // full-strobe fill, three words in every built bank
        for (int t = 0; t < num_tiles; t++)
            for (int b = 0; b < NUM_BANKS; b++)
                for (int o = 0; o < 3; o++)
                    add_op(OP_WRITE, make_addr(t, b, offsets[o]), rand_word(), '1);
        repeat (2) add_op(OP_IDLE, '0, '0, '0);
        // back-to-back readback, tiles and banks interleaved
        for (int o = 0; o < 3; o++)
            for (int b = 0; b < NUM_BANKS; b++)
                for (int t = 0; t < num_tiles; t++)
                    add_op(OP_READ, make_addr(t, b, offsets[o]), '0, '0);
        // last word must hold through these
        repeat (4) add_op(OP_IDLE, '0, '0, '0);
        // partial strobes over known words
        add_op(OP_WRITE, make_addr(1, 0, 17), rand_word(), 8'b1010_0101);
        add_op(OP_READ, make_addr(1, 0, 17), '0, '0);
        add_op(OP_WRITE, make_addr(2, 1, 0), rand_word(), 8'h0f);
        add_op(OP_WRITE, make_addr(0, 1, 63), rand_word(), 8'h80);
        add_op(OP_READ, make_addr(2, 1, 0), '0, '0);
        add_op(OP_READ, make_addr(0, 1, 63), '0, '0);
        repeat (3) add_op(OP_IDLE, '0, '0, '0);
        // column 3 is not built
        add_op(OP_READ, make_addr(3, 0, 0), '0, '0);
        add_op(OP_WRITE, make_addr(3, 0, 0), rand_word(), '1);
        add_op(OP_WRITE, make_addr(3, 1, 63), rand_word(), '1);
        add_op(OP_READ, make_addr(3, 0, 0), '0, '0);
        // built tiles unchanged by those writes
        for (int t = 0; t < num_tiles; t++) begin
            add_op(OP_READ, make_addr(t, 0, 0), '0, '0);
            add_op(OP_READ, make_addr(t, 1, 63), '0, '0);
        end
        add_op(OP_READ, make_addr(3, 1, 63), '0, '0);
        repeat (4) add_op(OP_IDLE, '0, '0, '0);
    endtask

    // drive one row and update the reference model
    task automatic drive_op(input op_t op, input int row);
        logic [TILE_SEL_ADDR_WIDTH-1:0] tile;
        tile    = op.addr[GLB_ADDR_WIDTH-1 -: TILE_SEL_ADDR_WIDTH];
        wr_en   = (op.kind == OP_WRITE);
        wr_strb = op.strb;
        wr_addr = op.addr;
        wr_data = op.data;
        rd_en   = (op.kind == OP_READ);
        rd_addr = op.addr;
        if (op.kind == OP_WRITE && tile < num_tiles) begin
            ref_mem[op.addr] = merge_bytes(ref_mem[op.addr], op.data, op.strb);
        end
        if (op.kind == OP_READ) begin
            // unbuilt column reads zero
            exp_word.push_back((tile < num_tiles) ? ref_mem[op.addr] : '0);
            exp_row.push_back(row);
        end
    endtask

    // a read returns two rows after its own; otherwise the last word holds
    task automatic check_rd_data(input int row);
        logic [BANK_DATA_WIDTH-1:0] expected;
        expected = last_word;
        if (exp_row.size() > 0 && exp_row[0] == row - 2) begin
            expected = exp_word.pop_front();
            void'(exp_row.pop_front());
            last_word = expected;
        end
        check_count++;
        if (rd_data !== expected) begin
            error_count++;
            $display("[FAIL] t=%0t row %0d: rd_data %h, expected %h",
                     $time, row, rd_data, expected);
        end
    endtask

    // watchdog, table length plus reset plus margin
    initial begin
        wait (table_ready === 1'b1);
        limit_ns = longint'(op_table.size() + reset_cycles + 40) * clk_period;
        #(limit_ns);
        $display("timeout: table not finished after %0d ns", limit_ns);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        wr_en       = 1'b0;
        wr_strb     = '0;
        wr_addr     = '0;
        wr_data     = '0;
        rd_en       = 1'b0;
        rd_addr     = '0;
        table_ready = 1'b0;
        lcg_state   = 32'hc411;
        error_count = 0;
        check_count = 0;
        last_word   = '0;
        for (int i = 0; i < 2**GLB_ADDR_WIDTH; i++) begin
            ref_mem[i] = '0;
        end
        build_table();
        table_ready = 1'b1;

        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int i = 0; i < op_table.size(); i++) begin
            @(negedge clk);
            check_rd_data(i);
            drive_op(op_table[i], i);
        end

        if (exp_word.size() != 0) begin
            error_count++;
            $display("%0d reads never checked at the end of the table", exp_word.size());
        end
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
